// ==== verilog/cpuPkg.sv ====
package cpuPkg;

        // Datapath widths.
        localparam int wordBits = 32;
        localparam int numRegs = 16;
        localparam int memWords = 512;

        typedef logic [wordBits-1:0]          wordT;
        typedef logic [2*wordBits-1:0]        wideT;    // Z holds a full product.
        typedef logic [$clog2(numRegs)-1:0]   regIdxT;
        typedef logic [numRegs-1:0]           regSelT;  // One-hot register select.
        typedef logic [$clog2(memWords)-1:0]  memAddrT;
        typedef logic [4:0]                   aluOpT;

        // ALU operation codes, same numbering as the instruction opcodes.
        localparam aluOpT opAdd = 5'b00011;
        localparam aluOpT opSub = 5'b00100;
        localparam aluOpT opAnd = 5'b00101;
        localparam aluOpT opOr  = 5'b00110;
        localparam aluOpT opShr = 5'b00111;
        localparam aluOpT opShl = 5'b01001;
        localparam aluOpT opMul = 5'b01111;
        localparam aluOpT opNeg = 5'b10001;
        localparam aluOpT opNot = 5'b10010;

        // C2 branch conditions in IR[20:19].
        localparam logic [1:0] condNever    = 2'b00;
        localparam logic [1:0] condZero     = 2'b01;
        localparam logic [1:0] condNonZero  = 2'b10;
        localparam logic [1:0] condNegative = 2'b11;

        // Instruction register fields.
        localparam int raMsb = 26;
        localparam int rbMsb = 22;
        localparam int rcMsb = 18;
        localparam int constBits = 19;

endpackage

// ==== verilog/memPortIf.sv ====
`timescale 1ns/1ps

interface memPortIf;
        import cpuPkg::*;

        memAddrT addr;
        wordT    wrData;
        wordT    rdData;
        logic    write;

        // MAR/MDR side.
        modport host (
                output addr, wrData, write,
                input  rdData
        );

        // RAM side.
        modport mem (
                input  addr, wrData, write,
                output rdData
        );

endinterface

// ==== verilog/ramArray.sv ====
`timescale 1ns/1ps

module ramArray (
        input logic  Clock,
        memPortIf.mem port
);
        import cpuPkg::*;

        wordT words [memWords];

        // Read is combinational.
        assign port.rdData = words[port.addr];

        always_ff @(posedge Clock) begin
                if (port.write) begin
                        words[port.addr] <= port.wrData;
                end
        end

endmodule

// ==== verilog/memUnit.sv ====
`timescale 1ns/1ps

module memUnit (
        input  logic         Clock,
        input  logic         arstN,
        input  logic         marLoad,
        input  logic         mdrLoad,
        input  logic         read,
        input  logic         write,
        input  cpuPkg::wordT busIn,
        output cpuPkg::wordT mdrData,
        memPortIf            mem
);
        import cpuPkg::*;

        wordT mar;
        wordT mdr;

        always_ff @(posedge Clock or negedge arstN) begin
                if (!arstN) begin
                        mar <= '0;
                        mdr <= '0;
                end else begin
                        if (marLoad) mar <= busIn;
                        if (mdrLoad) mdr <= read ? mem.rdData : busIn;
                end
        end

        // Only the low MAR bits reach the RAM.
        assign mem.addr = memAddrT'(mar);
        assign mem.wrData = mdr;
        assign mem.write = write;

        assign mdrData = mdr;

        ramArray ram (
                .Clock (Clock),
                .port  (mem.mem)
        );

        // A step either reads or writes memory.
        noReadWrite: assert property (
                @(posedge Clock) disable iff (!arstN)
                !(read && write)
        );

endmodule

// ==== verilog/regFile.sv ====
`timescale 1ns/1ps

module regFile (
        input  logic           Clock,
        input  logic           arstN,
        input  cpuPkg::regSelT writeSel,
        input  cpuPkg::regSelT readSel,
        input  logic           baseMode,
        input  cpuPkg::wordT   busIn,
        output cpuPkg::wordT   readData
);
        import cpuPkg::*;

        wordT regs [numRegs];

        always_ff @(posedge Clock or negedge arstN) begin
                if (!arstN) begin
                        for (int i = 0; i < numRegs; i++) begin
                                regs[i] <= '0;
                        end
                end else begin
                        for (int i = 0; i < numRegs; i++) begin
                                if (writeSel[i]) begin
                                        regs[i] <= busIn;
                                end
                        end
                end
        end

        // One-hot read mux.
        always_comb begin
                readData = '0;
                for (int i = 0; i < numRegs; i++) begin
                        if (readSel[i]) begin
                                readData = readData | regs[i];
                        end
                end
                // R0 reads as zero for absolute addressing.
                if (baseMode && readSel[0]) begin
                        readData = '0;
                end
        end

        // Selects come decoded from IR, never more than one register.
        selOneHot: assert property (
                @(posedge Clock) disable iff (!arstN)
                $onehot0(writeSel) && $onehot0(readSel)
        );

endmodule

// ==== verilog/irDecode.sv ====
`timescale 1ns/1ps

module irDecode (
        input  logic           Clock,
        input  logic           arstN,
        input  logic           irLoad,
        input  logic           gra,
        input  logic           grb,
        input  logic           grc,
        input  logic           rLoad,
        input  logic           rDrive,
        input  logic           baDrive,
        input  logic           conLoad,
        input  cpuPkg::wordT   busIn,
        output cpuPkg::regSelT writeSel,
        output cpuPkg::regSelT readSel,
        output logic           baseMode,
        output cpuPkg::wordT   constant,
        output logic           conOut
);
        import cpuPkg::*;

        wordT   ir;
        regIdxT regIdx;
        regSelT decoded;
        logic   condMet;
        logic   conReg;

        always_ff @(posedge Clock or negedge arstN) begin
                if (!arstN) begin
                        ir <= '0;
                        conReg <= 1'b0;
                end else begin
                        if (irLoad) ir <= busIn;
                        if (conLoad) conReg <= condMet;
                end
        end

        // Field select, Ra wins over Rb over Rc.
        always_comb begin
                regIdx = '0;
                if (gra) regIdx = ir[raMsb -: 4];
                else if (grb) regIdx = ir[rbMsb -: 4];
                else if (grc) regIdx = ir[rcMsb -: 4];
        end

        assign decoded = (gra || grb || grc) ? regSelT'(1) << regIdx : '0;
        assign writeSel = rLoad ? decoded : '0;
        assign readSel = (rDrive || baDrive) ? decoded : '0;
        assign baseMode = baDrive;

        assign constant = {{(wordBits - constBits){ir[constBits-1]}}, ir[constBits-1:0]};

        always_comb begin
                unique case (ir[20:19])
                        condNever:    condMet = 1'b0;
                        condZero:     condMet = (busIn == '0);
                        condNonZero:  condMet = (busIn != '0);
                        condNegative: condMet = busIn[wordBits-1];
                endcase
        end

        assign conOut = conReg;

endmodule

// ==== verilog/aluUnit.sv ====
`timescale 1ns/1ps

module aluUnit (
        input  logic          Clock,
        input  logic          arstN,
        input  logic          yLoad,
        input  logic          zLoad,
        input  logic          incPc,
        input  cpuPkg::aluOpT aluOp,
        input  cpuPkg::wordT  busIn,
        output cpuPkg::wordT  zLow,
        output cpuPkg::wordT  zHigh
);
        import cpuPkg::*;

        wordT              yReg;
        wideT              zReg;
        wideT              result;
        logic signed [2*wordBits-1:0] product;
        logic [4:0]        shamt;

        assign shamt = busIn[4:0];

        // Both operands sign extend to the 64-bit context.
        assign product = $signed(yReg) * $signed(busIn);

        always_comb begin
                result = '0;
                if (incPc) begin
                        result = wideT'(busIn + 32'd1);
                end else begin
                        case (aluOp)
                                opAdd: result = wideT'(yReg + busIn);
                                opSub: result = wideT'(yReg - busIn);
                                opAnd: result = wideT'(yReg & busIn);
                                opOr:  result = wideT'(yReg | busIn);
                                opShr: result = wideT'(yReg >> shamt);  // Logical.
                                opShl: result = wideT'(yReg << shamt);
                                opNeg: result = wideT'(-busIn);
                                opNot: result = wideT'(~busIn);
                                opMul: result = wideT'(product);
                                default: result = '0;
                        endcase
                end
        end

        always_ff @(posedge Clock or negedge arstN) begin
                if (!arstN) begin
                        yReg <= '0;
                end else if (yLoad) begin
                        yReg <= busIn;
                end
        end

        always_ff @(posedge Clock or negedge arstN) begin
                if (!arstN) begin
                        zReg <= '0;
                end else if (zLoad) begin
                        zReg <= result;
                end
        end

        assign zLow = zReg[wordBits-1:0];
        assign zHigh = zReg[2*wordBits-1:wordBits];

        // PC increment always rides on a Z load.
        incWithZ: assert property (
                @(posedge Clock) disable iff (!arstN)
                incPc |-> zLoad
        );

endmodule

// ==== verilog/busDatapath.sv ====
`timescale 1ns/1ps

module busDatapath (
        input  logic          Clock,
        input  logic          arstN,
        input  logic          pcDrive, zLowDrive, zHighDrive, mdrDrive, hiDrive,
        input  logic          loDrive, cDrive, inPortDrive, rDrive, baDrive,
        input  logic          pcLoad, marLoad, mdrLoad, irLoad, yLoad, zLoad,
        input  logic          hiLoad, loLoad, rLoad, conLoad, outPortLoad,
        input  logic          read, write, incPc, gra, grb, grc,
        input  cpuPkg::aluOpT aluOp,
        input  cpuPkg::wordT  inPort,
        output cpuPkg::wordT  outPort,
        output cpuPkg::wordT  busData,
        output logic          conOut
);
        import cpuPkg::*;

        wordT   bus;
        wordT   pc, hi, lo, outReg;
        wordT   regData, zLow, zHigh, mdrData, constant;
        regSelT writeSel, readSel;
        logic   baseMode;

        memPortIf memBus ();

        regFile regs (
                .Clock, .arstN, .writeSel, .readSel, .baseMode,
                .busIn (bus), .readData (regData)
        );

        irDecode decode (
                .Clock, .arstN, .irLoad, .gra, .grb, .grc, .rLoad, .rDrive,
                .baDrive, .conLoad, .busIn (bus), .writeSel, .readSel,
                .baseMode, .constant, .conOut
        );

        aluUnit alu (
                .Clock, .arstN, .yLoad, .zLoad, .incPc, .aluOp,
                .busIn (bus), .zLow, .zHigh
        );

        memUnit memory (
                .Clock, .arstN, .marLoad, .mdrLoad, .read, .write,
                .busIn (bus), .mdrData, .mem (memBus)
        );

        // And-or bus mux, zero when idle.
        assign bus = ({wordBits{pcDrive}}     & pc)
                   | ({wordBits{zLowDrive}}   & zLow)
                   | ({wordBits{zHighDrive}}  & zHigh)
                   | ({wordBits{mdrDrive}}    & mdrData)
                   | ({wordBits{hiDrive}}     & hi)
                   | ({wordBits{loDrive}}     & lo)
                   | ({wordBits{cDrive}}      & constant)
                   | ({wordBits{inPortDrive}} & inPort)
                   | ({wordBits{rDrive || baDrive}} & regData);

        always_ff @(posedge Clock or negedge arstN) begin
                if (!arstN) begin
                        pc <= '0;
                        hi <= '0;
                        lo <= '0;
                        outReg <= '0;
                end else begin
                        if (pcLoad) pc <= bus;
                        if (hiLoad) hi <= bus;
                        if (loLoad) lo <= bus;
                        if (outPortLoad) outReg <= bus;
                end
        end

        assign outPort = outReg;
        assign busData = bus;

        oneDriver: assert property (
                @(posedge Clock) disable iff (!arstN)
                $onehot0({pcDrive, zLowDrive, zHighDrive, mdrDrive, hiDrive,
                          loDrive, cDrive, inPortDrive, rDrive, baDrive})
        );

endmodule

// ==== testbench/datapathTb.sv ====
`timescale 1ns/1ps

module datapathTb;
        import cpuPkg::*;

        localparam int clkPeriod = 40;
        localparam int resetCycles = 16;
        localparam int ctlBits = 27;

        typedef logic [ctlBits-1:0] stepT;

        // Strobe bits, same order as the DUT control ports.
        typedef enum logic [ctlBits-1:0] {
                pcDrv = 27'h0000001, zLoDrv = 27'h0000002, zHiDrv = 27'h0000004,
                mdrDrv = 27'h0000008, hiDrv = 27'h0000010, loDrv = 27'h0000020,
                cDrv = 27'h0000040, inDrv = 27'h0000080, rDrv = 27'h0000100,
                baDrv = 27'h0000200, pcLd = 27'h0000400, marLd = 27'h0000800,
                mdrLd = 27'h0001000, irLd = 27'h0002000, yLd = 27'h0004000,
                zLd = 27'h0008000, hiLd = 27'h0010000, loLd = 27'h0020000,
                rLd = 27'h0040000, conLd = 27'h0080000, outLd = 27'h0100000,
                rd = 27'h0200000, wr = 27'h0400000, inc = 27'h0800000,
                selA = 27'h1000000, selB = 27'h2000000, selC = 27'h4000000
        } ctlBitT;

        typedef struct packed {
                stepT  ctl;
                aluOpT op;
                wordT  inPort;
                wordT  expBus;
                logic  chkOut;
                wordT  expOut;
                logic  chkCon;
                logic  expCon;
        } rowT;

        logic  Clock = 1'b0;
        logic  arstN;
        stepT  ctl;
        aluOpT aluOp;
        wordT  inPort;
        wordT  outPort;
        wordT  busData;
        logic  conOut;

        rowT steps [$];
        int  errors = 0;
        int  checks = 0;
        int  cycles = 0;
        int  cycleLimit = 0;

        busDatapath DUT (
                .Clock, .arstN,
                .pcDrive (ctl[0]), .zLowDrive (ctl[1]), .zHighDrive (ctl[2]),
                .mdrDrive (ctl[3]), .hiDrive (ctl[4]), .loDrive (ctl[5]),
                .cDrive (ctl[6]), .inPortDrive (ctl[7]), .rDrive (ctl[8]),
                .baDrive (ctl[9]), .pcLoad (ctl[10]), .marLoad (ctl[11]),
                .mdrLoad (ctl[12]), .irLoad (ctl[13]), .yLoad (ctl[14]),
                .zLoad (ctl[15]), .hiLoad (ctl[16]), .loLoad (ctl[17]),
                .rLoad (ctl[18]), .conLoad (ctl[19]), .outPortLoad (ctl[20]),
                .read (ctl[21]), .write (ctl[22]), .incPc (ctl[23]),
                .gra (ctl[24]), .grb (ctl[25]), .grc (ctl[26]),
                .aluOp, .inPort, .outPort, .busData, .conOut
        );

        always #(clkPeriod / 2) Clock = ~Clock;

        always @(posedge Clock) begin
                if (cycleLimit > 0) begin
                        cycles++;
                        if (cycles > cycleLimit) begin
                                $display("Timeout: the step table ran past %0d cycles", cycleLimit);
                                $display("Checks: %0d, errors: %0d", checks, errors + 1);
                                $display("Test failed");
                                $finish;
                        end
                end
        end

        function automatic wordT signExt19(logic [18:0] c);
                return {{13{c[18]}}, c};
        endfunction

        // Expected ALU result, Y on the left and the bus on the right.
        function automatic wordT aluModel(aluOpT op, wordT a, wordT b);
                case (op)
                        opAdd: return a + b;
                        opSub: return a - b;
                        opAnd: return a & b;
                        opOr:  return a | b;
                        opShr: return a >> b[4:0];
                        opShl: return a << b[4:0];
                        opNeg: return -b;
                        opNot: return ~b;
                        default: return '0;
                endcase
        endfunction

        task automatic addRow(stepT c, aluOpT op, wordT inp, wordT eBus);
                rowT r;
                r = '0;
                r.ctl = c;
                r.op = op;
                r.inPort = inp;
                r.expBus = eBus;
                steps.push_back(r);
        endtask

        // Idle step that also checks the output ports.
        task automatic idleCheck(logic cOut, wordT eOut, logic cCon, logic eCon);
                rowT r;
                r = '0;
                r.chkOut = cOut;
                r.expOut = eOut;
                r.chkCon = cCon;
                r.expCon = eCon;
                steps.push_back(r);
        endtask

        task automatic buildSteps();
                wordT w1, a1, pc0, instr, base, addr, storeVal, r0Val, absAddr;
                wordT opA, opB, v;
                logic [18:0] cLd, cAbs;
                logic signed [63:0] pa, pb, prod;
                aluOpT ops [8];
                wordT vals [3];
                logic expCon;
                ops = '{opAdd, opSub, opAnd, opOr, opShr, opShl, opNeg, opNot};
                idleCheck(1'b1, '0, 1'b1, 1'b0);

                // RAM write, then read back through MDR.
                w1 = $urandom;
                a1 = $urandom % memWords;
                addRow(inDrv | marLd, opAdd, a1, a1);
                addRow(inDrv | mdrLd, opAdd, w1, w1);
                addRow(wr, opAdd, '0, '0);
                addRow(inDrv | mdrLd, opAdd, '0, '0);
                addRow(rd | mdrLd, opAdd, '0, '0);
                addRow(mdrDrv, opAdd, '0, w1);

                // Fetch of a load instruction, Ra = 5 and Rb = 3.
                pc0 = $urandom % memWords;
                cLd = $urandom;
                instr = {5'b0, 4'd5, 4'd3, cLd};
                addRow(inDrv | pcLd, opAdd, pc0, pc0);
                addRow(inDrv | marLd, opAdd, pc0, pc0);
                addRow(inDrv | mdrLd, opAdd, instr, instr);
                addRow(wr, opAdd, '0, '0);
                addRow(inDrv | mdrLd, opAdd, '0, '0);
                addRow(inDrv | yLd, opAdd, ~pc0, ~pc0);        // Y must not reach PC + 1.
                addRow(pcDrv | marLd | inc | zLd, opAdd, '0, pc0);
                addRow(zLoDrv | pcLd | rd | mdrLd, opAdd, '0, pc0 + 1);
                addRow(mdrDrv | irLd, opAdd, '0, instr);
                addRow(pcDrv, opAdd, '0, pc0 + 1);

                // Store R5 to C(R3), clear R5, load it back.
                base = $urandom;
                storeVal = $urandom;
                addr = base + signExt19(cLd);
                addRow(inDrv | selB | rLd, opAdd, base, base);
                addRow(inDrv | selA | rLd, opAdd, storeVal, storeVal);
                addRow(selB | baDrv | yLd, opAdd, '0, base);
                addRow(cDrv | zLd, opAdd, '0, signExt19(cLd));
                addRow(zLoDrv | marLd, opAdd, '0, addr);
                addRow(selA | rDrv | mdrLd, opAdd, '0, storeVal);
                addRow(wr, opAdd, '0, '0);
                addRow(inDrv | selA | rLd, opAdd, '0, '0);
                addRow(inDrv | mdrLd, opAdd, '0, '0);
                addRow(selB | baDrv | yLd, opAdd, '0, base);
                addRow(cDrv | zLd, opAdd, '0, signExt19(cLd));
                addRow(zLoDrv | marLd, opAdd, '0, addr);
                addRow(rd | mdrLd, opAdd, '0, '0);
                addRow(mdrDrv | selA | rLd, opAdd, '0, storeVal);
                addRow(selA | rDrv, opAdd, '0, storeVal);

                // Base R0 under baDrive reads zero, so the address is C.
                cAbs = $urandom;
                r0Val = $urandom | 32'd1;
                storeVal = $urandom;
                absAddr = signExt19(cAbs);
                addRow(inDrv | irLd, opAdd, {5'b0, 4'd5, 4'd0, cAbs}, {5'b0, 4'd5, 4'd0, cAbs});
                addRow(inDrv | selB | rLd, opAdd, r0Val, r0Val);
                addRow(selB | rDrv, opAdd, '0, r0Val);
                addRow(selB | baDrv | yLd, opAdd, '0, '0);
                addRow(cDrv | zLd, opAdd, '0, absAddr);
                addRow(inDrv | selA | rLd, opAdd, storeVal, storeVal);
                addRow(zLoDrv | marLd, opAdd, '0, absAddr);
                addRow(selA | rDrv | mdrLd, opAdd, '0, storeVal);
                addRow(wr, opAdd, '0, '0);
                addRow(inDrv | mdrLd, opAdd, '0, '0);
                addRow(inDrv | marLd, opAdd, absAddr, absAddr);
                addRow(rd | mdrLd, opAdd, '0, '0);
                addRow(mdrDrv, opAdd, '0, storeVal);

                // ALU ops with the result kept in Rc.
                foreach (ops[i]) begin
                        opA = $urandom;
                        opB = $urandom;
                        v = aluModel(ops[i], opA, opB);
                        addRow(inDrv | yLd, opAdd, opA, opA);
                        addRow(inDrv | zLd, ops[i], opB, opB);
                        addRow(zLoDrv | selC | rLd, opAdd, '0, v);
                        addRow(selC | rDrv, opAdd, '0, v);
                end

                // Signed multiply through HI and LO.
                opA = $urandom;
                opB = $urandom;
                pa = $signed(opA);
                pb = $signed(opB);
                prod = pa * pb;
                addRow(inDrv | yLd, opAdd, opA, opA);
                addRow(inDrv | zLd, opMul, opB, opB);
                addRow(zHiDrv | hiLd, opAdd, '0, prod[63:32]);
                addRow(zLoDrv | loLd, opAdd, '0, prod[31:0]);
                addRow(hiDrv, opAdd, '0, prod[63:32]);
                addRow(loDrv | outLd, opAdd, '0, prod[31:0]);
                idleCheck(1'b1, prod[31:0], 1'b0, 1'b0);

                // Branch conditions on R2.
                vals[0] = '0;
                vals[1] = ($urandom & 32'h7fff_ffff) | 32'd1;
                vals[2] = $urandom | 32'h8000_0000;
                for (int c = 0; c < 4; c++) begin
                        instr = {5'b0, 4'd2, 2'b0, 2'(c), 19'b0};
                        addRow(inDrv | irLd, opAdd, instr, instr);
                        foreach (vals[j]) begin
                                case (c)
                                        0: expCon = 1'b0;
                                        1: expCon = (vals[j] == 0);
                                        2: expCon = (vals[j] != 0);
                                        default: expCon = vals[j][31];
                                endcase
                                addRow(inDrv | selA | rLd, opAdd, vals[j], vals[j]);
                                addRow(selA | rDrv | conLd, opAdd, '0, vals[j]);
                                idleCheck(1'b0, '0, 1'b1, expCon);
                        end
                end
        endtask

        task automatic runSteps();
                rowT row;
                for (int k = 0; k < steps.size(); k++) begin
                        row = steps[k];
                        @(posedge Clock);
                        ctl <= row.ctl;
                        aluOp <= row.op;
                        inPort <= row.inPort;
                        #(clkPeriod - 2);       // Just ahead of the next edge.
                        checks++;
                        if (busData !== row.expBus) begin
                                errors++;
                                $display("FAILED row %0d: busData expected %h, got %h",
                                         k, row.expBus, busData);
                        end
                        if (row.chkOut) begin
                                checks++;
                                if (outPort !== row.expOut) begin
                                        errors++;
                                        $display("FAILED row %0d: outPort expected %h, got %h",
                                                 k, row.expOut, outPort);
                                end
                        end
                        if (row.chkCon) begin
                                checks++;
                                if (conOut !== row.expCon) begin
                                        errors++;
                                        $display("FAILED row %0d: conOut expected %h, got %h",
                                                 k, row.expCon, conOut);
                                end
                        end
                end
                @(posedge Clock);
                ctl <= '0;
        endtask

        initial begin
                arstN = 1'b0;
                ctl = '0;
                aluOp = '0;
                inPort = '0;
                void'($urandom(50));
                buildSteps();
                repeat (resetCycles) @(posedge Clock);
                arstN <= 1'b1;
                cycleLimit = steps.size() + 64;
                runSteps();
                $display("Checks: %0d, errors: %0d", checks, errors);
                if (errors == 0) begin
                        $display("Test completed successfully");
                end else begin
                        $display("Test failed");
                end
                $finish;
        end

endmodule

// ==== all.f ====
verilog/cpuPkg.sv
verilog/memPortIf.sv
verilog/ramArray.sv
verilog/memUnit.sv
verilog/regFile.sv
verilog/irDecode.sv
verilog/aluUnit.sv
verilog/busDatapath.sv
testbench/datapathTb.sv

// ==== Bender.yml ====
package:
  name: bus_datapath

sources:
  - verilog/cpuPkg.sv
  - verilog/memPortIf.sv
  - verilog/ramArray.sv
  - verilog/memUnit.sv
  - verilog/regFile.sv
  - verilog/irDecode.sv
  - verilog/aluUnit.sv
  - verilog/busDatapath.sv
  - target: test
    files:
      - testbench/datapathTb.sv
